/* hw/axi_mem_pkg.sv */
/*
 * shared definitions for the AXI3 memory slave
 *   bus widths, burst and response encodings,
 *   the address-channel request struct, controller states
 *   and a beat size helper
 */
`default_nettype none

package axi_mem_pkg;

        ////////////////////////////////////////
        // bus widths
        ////////////////////////////////////////
        localparam int ID_W     = 4;
        localparam int ADDR_W   = 32;
        localparam int DATA_W   = 32;
        localparam int STRB_W   = DATA_W / 8;   // one lane per byte
        localparam int LEN_W    = 4;            // beats = len + 1
        localparam int SIZE_W   = 3;
        localparam int MAX_SIZE = 2;            // 4 bytes, full bus

        // burst type, codes 2 and 3 behave as INCR
        typedef enum logic [1:0] {
                FIXED = 2'd0,
                INCR  = 2'd1
        } burst_e;

        typedef enum logic [1:0] {
                OKAY   = 2'd0,
                SLVERR = 2'd2,          // size wider than the bus
                DECERR = 2'd3           // start address outside memory
        } resp_e;

        // payload of AW and AR, 45 bits
        typedef struct packed {
                logic [ID_W-1:0]   id;
                logic [ADDR_W-1:0] addr;
                logic [LEN_W-1:0]  len;
                logic [SIZE_W-1:0] size;
                burst_e            burst;
        } addr_req_t;

        typedef enum logic [1:0] {
                IDLE  = 2'd0,
                WDATA = 2'd1,
                BRESP = 2'd2,
                RDATA = 2'd3
        } ctrl_state_e;

        // bytes per beat for a size code
        function automatic logic [ADDR_W-1:0] beat_bytes(input logic [SIZE_W-1:0] size);
                logic [ADDR_W-1:0] one;
                one = {{(ADDR_W-1){1'b0}}, 1'b1};
                return one << size;
        endfunction

endpackage

`default_nettype wire

/* hw/axi_beat_counter.sv */
/*
 * burst address and beat counter
 *   FIXED and INCR address stepping, last beat flag
 */
`default_nettype none

module axi_beat_counter (
        input  wire                                 clk,
        input  wire                                 resetn,
        input  wire                                 load,
        input  axi_mem_pkg::addr_req_t              load_req,
        input  wire                                 step,
        output logic [axi_mem_pkg::ADDR_W-1:0]      cur_addr,
        output logic                                last
);

        logic [axi_mem_pkg::LEN_W-1:0]          cnt_q;
        logic [axi_mem_pkg::LEN_W-1:0]          len_q;
        logic [axi_mem_pkg::ADDR_W-1:0]         addr_q;
        logic [axi_mem_pkg::SIZE_W-1:0]         size_q;
        axi_mem_pkg::burst_e                    burst_q;

        ////////////////////////////////////////
        // beat count
        ////////////////////////////////////////
        always_ff @(posedge clk or negedge resetn) begin
                if (!resetn) begin
                        cnt_q <= '0;
                        len_q <= '0;
                end else if (load) begin
                        cnt_q <= '0;
                        len_q <= load_req.len;
                end else if (step) begin
                        cnt_q <= cnt_q + 1'b1;  // wraps after the final beat
                end
        end

        ////////////////////////////////////////
        // current address
        ////////////////////////////////////////
        always_ff @(posedge clk) begin
                if (load) begin
                        addr_q  <= load_req.addr;
                        size_q  <= load_req.size;
                        burst_q <= load_req.burst;
                end else if (step && burst_q != axi_mem_pkg::FIXED) begin
                        // INCR and the unused codes advance by the beat size
                        addr_q <= addr_q + axi_mem_pkg::beat_bytes(size_q);
                end
        end

        assign cur_addr = addr_q;
        assign last     = (cnt_q == len_q);

endmodule

`default_nettype wire

/* hw/axi_mem_array.sv */
/*
 * word memory with per-byte-lane write enables
 *   written at the clock edge, read combinationally
 */
`default_nettype none

module axi_mem_array #(
        parameter int MEM_BYTES = 128
) (
        input  wire                                 clk,
        input  wire [axi_mem_pkg::ADDR_W-1:0]       addr,
        input  wire                                 we,
        input  wire [axi_mem_pkg::STRB_W-1:0]       strb,
        input  wire [axi_mem_pkg::DATA_W-1:0]       wdata,
        output logic [axi_mem_pkg::DATA_W-1:0]      rdata
);

        localparam int WORDS  = MEM_BYTES / axi_mem_pkg::STRB_W;
        localparam int IDX_W  = $clog2(WORDS);
        localparam int LSB    = $clog2(axi_mem_pkg::STRB_W);     // byte offset bits

        logic [axi_mem_pkg::STRB_W-1:0][7:0]    mem [WORDS];
        logic [IDX_W-1:0]                       idx;

        // high address bits ignored, so addresses past the end wrap
        assign idx = addr[LSB +: IDX_W];

        ////////////////////////////////////////
        // lane writes
        ////////////////////////////////////////
        always_ff @(posedge clk) begin
                for (int i = 0; i < axi_mem_pkg::STRB_W; i++) begin
                        if (we && strb[i])
                                mem[idx][i] <= wdata[8*i +: 8];    // lane i to byte i
                end
        end

        assign rdata = mem[idx];

endmodule

`default_nettype wire

/* hw/axi_mem_ctrl.sv */
/*
 * transaction FSM of the AXI3 memory slave
 *   write-first arbitration, response decode,
 *   channel handshakes and read data masking
 */
`default_nettype none

module axi_mem_ctrl #(
        parameter int MEM_BYTES = 128
) (
        input  wire                                 clk,
        input  wire                                 resetn,

        input  axi_mem_pkg::addr_req_t              aw,
        input  wire                                 awvalid,
        output logic                                awready,
        input  axi_mem_pkg::addr_req_t              ar,
        input  wire                                 arvalid,
        output logic                                arready,

        input  wire [axi_mem_pkg::STRB_W-1:0]       wstrb,
        input  wire                                 wvalid,
        output logic                                wready,

        output logic [axi_mem_pkg::ID_W-1:0]        bid,
        output axi_mem_pkg::resp_e                  bresp,
        output logic                                bvalid,
        input  wire                                 bready,

        output logic [axi_mem_pkg::ID_W-1:0]        rid,
        output logic [axi_mem_pkg::DATA_W-1:0]      rdata,
        output axi_mem_pkg::resp_e                  rresp,
        output logic                                rlast,
        output logic                                rvalid,
        input  wire                                 rready,

        // beat counter and memory side
        input  wire                                 last,
        input  wire [axi_mem_pkg::DATA_W-1:0]       mem_rdata,
        output logic                                load,
        output axi_mem_pkg::addr_req_t              load_req,
        output logic                                step,
        output logic                                mem_we,
        output logic [axi_mem_pkg::STRB_W-1:0]      mem_strb
);

        localparam logic [axi_mem_pkg::ADDR_W-1:0] MEM_LIMIT = MEM_BYTES;

        axi_mem_pkg::ctrl_state_e               state, state_d;
        logic [axi_mem_pkg::ID_W-1:0]           id_q;
        axi_mem_pkg::resp_e                     resp_q;
        logic                                   okay;

        // DECERR has priority over SLVERR
        function automatic axi_mem_pkg::resp_e decode_resp(input axi_mem_pkg::addr_req_t req);
                axi_mem_pkg::resp_e r;
                if (req.addr >= MEM_LIMIT)
                        r = axi_mem_pkg::DECERR;
                else if (req.size > axi_mem_pkg::MAX_SIZE)
                        r = axi_mem_pkg::SLVERR;
                else
                        r = axi_mem_pkg::OKAY;
                return r;
        endfunction

        ////////////////////////////////////////
        // arbitration, write wins a tie
        ////////////////////////////////////////
        assign awready  = (state == axi_mem_pkg::IDLE);
        assign arready  = (state == axi_mem_pkg::IDLE) && !awvalid;
        assign load     = (awvalid && awready) || (arvalid && arready);
        assign load_req = awvalid ? aw : ar;

        ////////////////////////////////////////
        // data and response channels
        ////////////////////////////////////////
        assign okay     = (resp_q == axi_mem_pkg::OKAY);
        assign wready   = (state == axi_mem_pkg::WDATA);
        assign bvalid   = (state == axi_mem_pkg::BRESP);
        assign rvalid   = (state == axi_mem_pkg::RDATA);

        assign bid      = id_q;
        assign bresp    = resp_q;
        assign rid      = id_q;
        assign rresp    = resp_q;
        assign rlast    = last;
        assign rdata    = okay ? mem_rdata : '0;        // zero on error

        assign step     = (wvalid && wready) || (rvalid && rready);
        assign mem_we   = wvalid && wready && okay;     // errored bursts write nothing
        assign mem_strb = mem_we ? wstrb : '0;

        always_comb begin
                state_d = state;
                case (state)
                axi_mem_pkg::IDLE: begin
                        if (awvalid)
                                state_d = axi_mem_pkg::WDATA;
                        else if (arvalid)
                                state_d = axi_mem_pkg::RDATA;
                end
                axi_mem_pkg::WDATA: begin
                        if (wvalid && last)
                                state_d = axi_mem_pkg::BRESP;
                end
                axi_mem_pkg::BRESP: begin
                        if (bready)
                                state_d = axi_mem_pkg::IDLE;
                end
                axi_mem_pkg::RDATA: begin
                        if (rready && last)
                                state_d = axi_mem_pkg::IDLE;
                end
                default: state_d = axi_mem_pkg::IDLE;
                endcase
        end

        always_ff @(posedge clk or negedge resetn) begin
                if (!resetn) begin
                        state  <= axi_mem_pkg::IDLE;
                        id_q   <= '0;
                        resp_q <= axi_mem_pkg::OKAY;
                end else begin
                        state <= state_d;
                        if (load) begin         // capture id and response of accepted request
                                id_q   <= load_req.id;
                                resp_q <= decode_resp(load_req);
                        end
                end
        end

endmodule

`default_nettype wire

/* hw/axi_mem_top.sv */
/*
 * AXI3 memory slave top level
 *   controller FSM, burst address counter and byte-lane memory
 */
`default_nettype none

module axi_mem_top #(
        parameter int MEM_BYTES = 128
) (
        input  wire                                 clk,
        input  wire                                 resetn,

        // write address
        input  axi_mem_pkg::addr_req_t              aw,
        input  wire                                 awvalid,
        output logic                                awready,

        // write data
        input  wire [axi_mem_pkg::DATA_W-1:0]       wdata,
        input  wire [axi_mem_pkg::STRB_W-1:0]       wstrb,
        input  wire                                 wvalid,
        output logic                                wready,

        // write response
        output logic [axi_mem_pkg::ID_W-1:0]        bid,
        output axi_mem_pkg::resp_e                  bresp,
        output logic                                bvalid,
        input  wire                                 bready,

        // read address
        input  axi_mem_pkg::addr_req_t              ar,
        input  wire                                 arvalid,
        output logic                                arready,

        // read data
        output logic [axi_mem_pkg::ID_W-1:0]        rid,
        output logic [axi_mem_pkg::DATA_W-1:0]      rdata,
        output axi_mem_pkg::resp_e                  rresp,
        output logic                                rlast,
        output logic                                rvalid,
        input  wire                                 rready
);

        ////////////////////////////////////////
        // internal wiring
        ////////////////////////////////////////
        logic                                   load;
        axi_mem_pkg::addr_req_t                 load_req;
        logic                                   step;
        logic [axi_mem_pkg::ADDR_W-1:0]         cur_addr;
        logic                                   last;
        logic                                   mem_we;
        logic [axi_mem_pkg::STRB_W-1:0]         mem_strb;
        logic [axi_mem_pkg::DATA_W-1:0]         mem_rdata;

        axi_mem_ctrl #(
                .MEM_BYTES (MEM_BYTES)
        ) u_ctrl (
                .clk       (clk),
                .resetn    (resetn),
                .aw        (aw),
                .awvalid   (awvalid),
                .awready   (awready),
                .ar        (ar),
                .arvalid   (arvalid),
                .arready   (arready),
                .wstrb     (wstrb),
                .wvalid    (wvalid),
                .wready    (wready),
                .bid       (bid),
                .bresp     (bresp),
                .bvalid    (bvalid),
                .bready    (bready),
                .rid       (rid),
                .rdata     (rdata),
                .rresp     (rresp),
                .rlast     (rlast),
                .rvalid    (rvalid),
                .rready    (rready),
                .last      (last),
                .mem_rdata (mem_rdata),
                .load      (load),
                .load_req  (load_req),
                .step      (step),
                .mem_we    (mem_we),
                .mem_strb  (mem_strb)
        );

        axi_beat_counter u_counter (
                .clk      (clk),
                .resetn   (resetn),
                .load     (load),
                .load_req (load_req),
                .step     (step),
                .cur_addr (cur_addr),
                .last     (last)
        );

        axi_mem_array #(
                .MEM_BYTES (MEM_BYTES)
        ) u_mem (
                .clk   (clk),
                .addr  (cur_addr),
                .we    (mem_we),
                .strb  (mem_strb),
                .wdata (wdata),
                .rdata (mem_rdata)
        );

endmodule

`default_nettype wire

/* sim/axi_mem_chk.sv */
/*
 * handshake assertions for the slave controller
 *   write response and read data held under back-pressure,
 *   write data and read data never open together,
 *   count of failed assertions
 */
`default_nettype none

module axi_mem_chk (
        input  wire                                 clk,
        input  wire                                 resetn,
        input  wire axi_mem_pkg::ctrl_state_e       state,
        input  wire                                 wready,
        input  wire                                 bvalid,
        input  wire                                 bready,
        input  wire [axi_mem_pkg::ID_W-1:0]         bid,
        input  wire axi_mem_pkg::resp_e             bresp,
        input  wire                                 rvalid,
        input  wire                                 rready,
        input  wire [axi_mem_pkg::ID_W-1:0]         rid,
        input  wire [axi_mem_pkg::DATA_W-1:0]       rdata,
        input  wire axi_mem_pkg::resp_e             rresp,
        input  wire                                 rlast
);

        int unsigned                            fail_count = 0;

        // response stays put until the master takes it
        property b_held;
                @(posedge clk) disable iff (!resetn)
                bvalid && !bready |=> state == axi_mem_pkg::BRESP && bvalid
                        && $stable(bid) && $stable(bresp);
        endproperty

        property r_held;
                @(posedge clk) disable iff (!resetn)
                rvalid && !rready |=> rvalid && $stable(rid) && $stable(rdata)
                        && $stable(rresp) && $stable(rlast);
        endproperty

        property w_r_exclusive;
                @(posedge clk) disable iff (!resetn)
                !(wready && rvalid);
        endproperty

        assert property (b_held)
                else begin
                        fail_count++;
                        $error("bvalid or its payload changed before bready");
                end
        assert property (r_held)
                else begin
                        fail_count++;
                        $error("rvalid or its payload changed before rready");
                end
        assert property (w_r_exclusive)
                else begin
                        fail_count++;
                        $error("wready and rvalid high together");
                end

endmodule

`default_nettype wire

/* sim/axi_mem_tb.sv */
/*
 * testbench for the AXI3 memory slave
 *   clock and reset, random INCR and FIXED bursts, error bursts,
 *   write-first tie, byte model of the memory and checks
 */
`default_nettype none

module axi_mem_tb;

        localparam int          MEM_BYTES  = 128;
        localparam int          DRIVE_DLY  = 10;        // after the rising edge
        localparam int          WAIT_LIMIT = 200;
        localparam logic [31:0] SEED       = 32'hbbc6a0ec;

        logic                                   clk;
        logic                                   resetn;
        axi_mem_pkg::addr_req_t                 aw;
        axi_mem_pkg::addr_req_t                 ar;
        logic                                   awvalid, awready, arvalid, arready;
        logic [axi_mem_pkg::DATA_W-1:0]         wdata;
        logic [axi_mem_pkg::STRB_W-1:0]         wstrb;
        logic                                   wvalid, wready;
        logic [axi_mem_pkg::ID_W-1:0]           bid, rid;
        axi_mem_pkg::resp_e                     bresp, rresp;
        logic                                   bvalid, bready;
        logic [axi_mem_pkg::DATA_W-1:0]         rdata;
        logic                                   rlast, rvalid, rready;

        logic [7:0]                             model_mem [MEM_BYTES];
        bit                                     known [MEM_BYTES];      // byte written by an OKAY burst

        axi_mem_top #(
                .MEM_BYTES (MEM_BYTES)
        ) uut (
                .clk (clk), .resetn (resetn),
                .aw (aw), .awvalid (awvalid), .awready (awready),
                .wdata (wdata), .wstrb (wstrb), .wvalid (wvalid), .wready (wready),
                .bid (bid), .bresp (bresp), .bvalid (bvalid), .bready (bready),
                .ar (ar), .arvalid (arvalid), .arready (arready),
                .rid (rid), .rdata (rdata), .rresp (rresp), .rlast (rlast),
                .rvalid (rvalid), .rready (rready)
        );

        bind axi_mem_ctrl axi_mem_chk u_chk (
                .clk (clk), .resetn (resetn), .state (state), .wready (wready),
                .bvalid (bvalid), .bready (bready), .bid (bid), .bresp (bresp),
                .rvalid (rvalid), .rready (rready), .rid (rid), .rdata (rdata),
                .rresp (rresp), .rlast (rlast)
        );

        initial begin
                clk = 1'b0;
                forever #50 clk = ~clk;
        end

        ////////////////////////////////////////
        // checking helpers
        ////////////////////////////////////////
        task automatic check_value(input string name, input logic [31:0] got,
                                   input logic [31:0] exp);
                if (got !== exp) begin
                        $display("MISMATCH at %0t: %s got %h expected %h", $time, name, got, exp);
                        $display("ERRORS FOUND");
                        $fatal(1, "stopped at first mismatch");
                end
        endtask

        task automatic timeout_fail(input string what);
                $display("TIMEOUT at %0t: waited too long for %s", $time, what);
                $display("ERRORS FOUND");
                $fatal(1, "stopped on timeout");
        endtask

        task automatic assertion_fail();
                $display("ASSERTION at %0t: a handshake rule of the slave was broken", $time);
                $display("ERRORS FOUND");
                $fatal(1, "stopped on assertion failure");
        endtask

        task automatic next_cycle();
                @(posedge clk);
                #DRIVE_DLY;
        endtask

        always @(negedge clk) begin
                if (uut.u_ctrl.u_chk.fail_count != 0)
                        assertion_fail();
        end

        // DECERR before SLVERR
        function automatic logic [1:0] expected_resp(input axi_mem_pkg::addr_req_t req);
                logic [1:0] r;
                if (req.addr >= MEM_BYTES)
                        r = 2'd3;
                else if (req.size > 3'd2)
                        r = 2'd2;
                else
                        r = 2'd0;
                return r;
        endfunction

        function automatic logic [31:0] beat_addr(input axi_mem_pkg::addr_req_t req, input int beat);
                logic [31:0] a;
                if (req.burst == axi_mem_pkg::FIXED)
                        a = req.addr;
                else
                        a = req.addr + (beat << req.size);
                return a;
        endfunction

        // model slot of lane j in the word holding the wrapped addr
        function automatic int byte_slot(input logic [31:0] addr, input int lane);
                logic [31:0] base;
                base = addr & (MEM_BYTES - 1);
                return int'(base & ~32'd3) + lane;
        endfunction

        function automatic axi_mem_pkg::addr_req_t make_req(input logic [31:0] addr,
                        input logic [2:0] size, input axi_mem_pkg::burst_e burst);
                axi_mem_pkg::addr_req_t req;
                req.id    = 4'($urandom % 16);
                req.addr  = addr;
                req.len   = 4'($urandom % 16);
                req.size  = size;
                req.burst = burst;
                return req;
        endfunction

        ////////////////////////////////////////
        // bus transactions
        ////////////////////////////////////////
        task automatic write_burst(input axi_mem_pkg::addr_req_t req);
                int          beat;
                int          waited;
                logic        okay;
                logic [31:0] a;
                okay    = (expected_resp(req) == 2'd0);
                aw      = req;
                awvalid = 1'b1;
                waited  = 0;
                @(negedge clk);
                while (!awready) begin
                        waited++;
                        if (waited > WAIT_LIMIT)
                                timeout_fail("awready");
                        @(negedge clk);
                end
                check_value("arready", arready, 32'd0);         // write wins
                next_cycle();
                awvalid = 1'b0;
                beat    = 0;
                waited  = 0;
                wdata   = $urandom;
                wstrb   = 4'($urandom % 16);
                wvalid  = ($urandom % 4) != 0;
                while (beat <= req.len) begin
                        @(negedge clk);
                        if (wvalid && wready) begin
                                a = beat_addr(req, beat);
                                for (int j = 0; j < axi_mem_pkg::STRB_W; j++) begin
                                        if (okay && wstrb[j]) begin
                                                model_mem[byte_slot(a, j)] = wdata[8*j +: 8];
                                                known[byte_slot(a, j)]     = 1'b1;
                                        end
                                end
                                beat++;
                                waited = 0;
                                next_cycle();
                                wdata = $urandom;
                                wstrb = 4'($urandom % 16);
                        end else begin
                                waited++;
                                if (waited > WAIT_LIMIT)
                                        timeout_fail("a write beat");
                                next_cycle();
                        end
                        wvalid = (beat <= req.len) && (($urandom % 4) != 0);
                end
                waited = 0;
                bready = ($urandom % 2) != 0;
                @(negedge clk);
                while (!(bvalid && bready)) begin
                        waited++;
                        if (waited > WAIT_LIMIT)
                                timeout_fail("the write response");
                        next_cycle();
                        bready = ($urandom % 2) != 0;
                        @(negedge clk);
                end
                check_value("bid", bid, req.id);
                check_value("bresp", bresp, expected_resp(req));
                next_cycle();
                bready = 1'b0;
        endtask

        task automatic read_burst(input axi_mem_pkg::addr_req_t req);
                int          beat;
                int          waited;
                int          slot;
                logic [1:0]  resp;
                logic [31:0] a;
                resp    = expected_resp(req);
                ar      = req;
                arvalid = 1'b1;
                waited  = 0;
                @(negedge clk);
                while (!arready) begin
                        waited++;
                        if (waited > WAIT_LIMIT)
                                timeout_fail("arready");
                        @(negedge clk);
                end
                next_cycle();
                arvalid = 1'b0;
                beat    = 0;
                waited  = 0;
                rready  = ($urandom % 4) != 0;
                while (beat <= req.len) begin
                        @(negedge clk);
                        if (rvalid && rready) begin
                                check_value("rid", rid, req.id);
                                check_value("rresp", rresp, resp);
                                check_value("rlast", rlast, beat == req.len);
                                if (resp == 2'd0) begin
                                        a = beat_addr(req, beat);
                                        for (int j = 0; j < axi_mem_pkg::STRB_W; j++) begin
                                                slot = byte_slot(a, j);
                                                if (known[slot])
                                                        check_value($sformatf("rdata[%0d]", j),
                                                                    rdata[8*j +: 8], model_mem[slot]);
                                        end
                                end else begin
                                        check_value("rdata", rdata, 32'd0);
                                end
                                beat++;
                                waited = 0;
                        end else begin
                                waited++;
                                if (waited > WAIT_LIMIT)
                                        timeout_fail("a read beat");
                        end
                        next_cycle();
                        rready = (beat <= req.len) && (($urandom % 4) != 0);
                end
        endtask

        ////////////////////////////////////////
        // test sequence
        ////////////////////////////////////////
        initial begin
                axi_mem_pkg::addr_req_t req;
                axi_mem_pkg::addr_req_t rd_req;
                void'($urandom(SEED));
                resetn  = 1'b0;
                aw      = '0;
                ar      = '0;
                awvalid = 1'b0;
                arvalid = 1'b0;
                wdata   = '0;
                wstrb   = '0;
                wvalid  = 1'b0;
                bready  = 1'b0;
                rready  = 1'b0;
                repeat (16) @(posedge clk);
                #DRIVE_DLY;
                resetn = 1'b1;
                @(negedge clk);
                check_value("wready", wready, 32'd0);
                check_value("bvalid", bvalid, 32'd0);
                check_value("rvalid", rvalid, 32'd0);
                check_value("awready", awready, 32'd1);
                check_value("arready", arready, 32'd1);
                next_cycle();

                repeat (40) begin                               // INCR round trips
                        req = make_req($urandom % MEM_BYTES, 3'($urandom % 3), axi_mem_pkg::INCR);
                        write_burst(req);
                        rd_req    = req;
                        rd_req.id = 4'($urandom % 16);
                        read_burst(rd_req);
                end
                repeat (20) begin                               // FIXED merges per lane
                        req = make_req($urandom % MEM_BYTES, 3'($urandom % 3), axi_mem_pkg::FIXED);
                        write_burst(req);
                        read_burst(req);
                end
                repeat (10) begin                               // DECERR then the wrapped range
                        req = make_req(MEM_BYTES + ($urandom % 1024), 3'($urandom % 3),
                                       axi_mem_pkg::INCR);
                        write_burst(req);
                        read_burst(req);
                        rd_req      = req;
                        rd_req.addr = req.addr % MEM_BYTES;
                        read_burst(rd_req);
                end
                repeat (10) begin                               // SLVERR on size 3 and up
                        req = make_req($urandom % MEM_BYTES, 3'(3 + $urandom % 5), axi_mem_pkg::INCR);
                        write_burst(req);
                        read_burst(req);
                        rd_req      = req;
                        rd_req.size = 3'd2;
                        read_burst(rd_req);
                end
                repeat (10) begin                               // AW and AR in the same cycle
                        req = make_req($urandom % MEM_BYTES, 3'($urandom % 3), axi_mem_pkg::INCR);
                        rd_req    = req;
                        rd_req.id = ~req.id;
                        ar        = rd_req;
                        arvalid   = 1'b1;
                        write_burst(req);
                        read_burst(rd_req);
                end

                if (uut.u_ctrl.u_chk.fail_count == 0) begin
                        $display("NO ERRORS");
                        $finish;
                end else begin
                        assertion_fail();
                end
        end

endmodule

`default_nettype wire

/* axi_mem.f */
hw/axi_mem_pkg.sv
hw/axi_beat_counter.sv
hw/axi_mem_array.sv
hw/axi_mem_ctrl.sv
hw/axi_mem_top.sv
sim/axi_mem_chk.sv
sim/axi_mem_tb.sv

/* Bender.yml */
package:
  name: axi_mem

sources:
  # package first, then the blocks, then the top level
  - files:
      - hw/axi_mem_pkg.sv
      - hw/axi_beat_counter.sv
      - hw/axi_mem_array.sv
      - hw/axi_mem_ctrl.sv
      - hw/axi_mem_top.sv

  # testbench and bound checker
  - target: simulation
    files:
      - sim/axi_mem_chk.sv
      - sim/axi_mem_tb.sv
